// ==== Makefile ====
TOP = tb_pm_subsystem

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

obj_dir/V$(TOP): tb.f *.sv *.svh
	verilator --binary --assert --timing --timescale 1ns/1ps -j 0 \
		-f tb.f --top-module $(TOP)

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// ==== pm_params.svh ====
`ifndef PM_PARAMS_SVH
`define PM_PARAMS_SVH

// system bus address width
`define PM_ADDR_W 16

// power manager window
// offset 0 is sleep/mask/lowpower, offset 1 is power level
`define PM_BASE_ADDR 16'hFF1F
`define PM_WIN_SIZE 2

// wake timer window
// reload lo, reload hi, control, status
`define TMR_BASE_ADDR 16'hFF20
`define TMR_WIN_SIZE 4

// low-power pwm
// the counter needs one extra bit so that a duty of 256 fits, which keeps
// the core enabled for the whole period at full power
`define PM_PWM_W 9
`define PM_PWM_PERIOD 256

// width of the wake timer reload value and counter
`define TMR_CNT_W 16

`endif

// ==== pm_pkg.sv ====
package pm_pkg;

    // field view of the sleep register, msb first
    typedef struct packed {
        logic [3:0] wake_mask;  // interrupt lines allowed to wake the core
        logic [1:0] reserved;   // stored and read back, no function
        logic       lowpower;   // pwm gating of the core enable
        logic       sleep;      // core halted while set
    } pm_sleep_fields_t;

    // the same byte as the bus moves it, or split into fields for control
    typedef union packed {
        logic [7:0]       raw;
        pm_sleep_fields_t f;
    } pm_sleep_u;

    // power manager register offsets
    typedef enum logic {
        PM_OFF_SLEEP = 1'b0,
        PM_OFF_POWER = 1'b1
    } pm_off_e;

    // wake timer register offsets
    // control: bit 0 run, bit 1 periodic
    // status: bit 0 fired, write 1 to clear
    typedef enum logic [1:0] {
        TMR_RELOAD_LO = 2'd0,
        TMR_RELOAD_HI = 2'd1,
        TMR_CTRL      = 2'd2,
        TMR_STATUS    = 2'd3
    } tmr_off_e;

endpackage

// ==== pm_regs.sv ====
`timescale 1ns/1ps

// sleep and power registers of the power manager
// a masked interrupt clears the sleep bit, even against a bus write to it
module pm_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              sel,       // window hit, enable already folded in
    input  pm_pkg::pm_off_e   offset,
    input  logic              write_en,
    input  logic [7:0]        data_in,
    output logic [7:0]        data_out,
    input  logic [3:0]        interrupts,
    output pm_pkg::pm_sleep_u sleep_reg,
    output logic [7:0]        power
);

    import pm_pkg::*;

    logic wr_sleep;
    logic wr_power;
    logic wake;

    assign wr_sleep = sel && write_en && (offset == PM_OFF_SLEEP);
    assign wr_power = sel && write_en && (offset == PM_OFF_POWER);

    // wake condition, mask taken from the register as it stands
    assign wake = |(sleep_reg.f.wake_mask & interrupts);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sleep_reg.raw <= 8'h00;
        end else begin
            if (wr_sleep) begin
                sleep_reg.raw <= data_in;
            end
            // later assignment wins, the other seven bits follow the write
            if (wake) begin
                sleep_reg.f.sleep <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            power <= 8'hFF;    // full power out of reset
        end else if (wr_power) begin
            power <= data_in;
        end
    end

    // read back, zero when another block owns the access
    always_comb begin
        data_out = 8'h00;
        if (sel) begin
            case (offset)
                PM_OFF_SLEEP: data_out = sleep_reg.raw;
                PM_OFF_POWER: data_out = power;
            endcase
        end
    end

endmodule

// ==== pm_subsystem.sv ====
`timescale 1ns/1ps
`include "pm_params.svh"

// power manager and wake timer on one system bus
module pm_subsystem (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enable,
    input  logic [`PM_ADDR_W-1:0] addr,
    input  logic                 write_en,
    input  logic [7:0]           data_in,
    output logic [7:0]           data_out,
    input  logic [3:1]           ext_irq,    // line 0 is the timer
    output logic                 cpu_enable
);

    import pm_pkg::*;

    logic [`PM_ADDR_W-1:0] pm_rel;
    logic [`PM_ADDR_W-1:0] tmr_rel;
    logic                  pm_sel;
    logic                  tmr_sel;
    pm_off_e               pm_off;
    tmr_off_e              tmr_off;
    logic [7:0]            pm_rdata;
    logic [7:0]            tmr_rdata;
    logic                  timer_irq;
    logic [3:0]            cpu_interrupts;

    // addresses below a base wrap to large values and miss the window
    assign pm_rel  = addr - `PM_BASE_ADDR;
    assign tmr_rel = addr - `TMR_BASE_ADDR;

    assign pm_sel  = enable && (pm_rel < `PM_WIN_SIZE);
    assign tmr_sel = enable && (tmr_rel < `TMR_WIN_SIZE);

    assign pm_off  = pm_off_e'(pm_rel[0]);
    assign tmr_off = tmr_off_e'(tmr_rel[1:0]);

    assign cpu_interrupts = {ext_irq, timer_irq};

    power_manager u_pm (
        .clk            (clk),
        .rst_n          (rst_n),
        .sel            (pm_sel),
        .offset         (pm_off),
        .write_en       (write_en),
        .data_in        (data_in),
        .data_out       (pm_rdata),
        .cpu_interrupts (cpu_interrupts),
        .cpu_enable     (cpu_enable)
    );

    wake_timer u_tmr (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel       (tmr_sel),
        .offset    (tmr_off),
        .write_en  (write_en),
        .data_in   (data_in),
        .data_out  (tmr_rdata),
        .timer_irq (timer_irq)
    );

    // unselected blocks drive zero, so a miss reads zero
    assign data_out = pm_rdata | tmr_rdata;

endmodule

// ==== power_manager.sv ====
`timescale 1ns/1ps
`include "pm_params.svh"

// power manager
// holds the core while sleeping, lets any masked interrupt wake it, and in
// low-power mode runs the core for power+1 cycles out of every 256
module power_manager (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            sel,
    input  pm_pkg::pm_off_e offset,
    input  logic            write_en,
    input  logic [7:0]      data_in,
    output logic [7:0]      data_out,
    input  logic [3:0]      cpu_interrupts,  // line 0 is the wake timer
    output logic            cpu_enable
);

    import pm_pkg::*;

    pm_sleep_u            sleep_reg;
    logic [7:0]           power;
    logic [`PM_PWM_W-1:0] duty;
    logic                 pwm_out;

    // registers, wake detection lives next to the sleep bit it clears
    pm_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .sel        (sel),
        .offset     (offset),
        .write_en   (write_en),
        .data_in    (data_in),
        .data_out   (data_out),
        .interrupts (cpu_interrupts),
        .sleep_reg  (sleep_reg),
        .power      (power)
    );

    // widen before the add so that power 0xFF gives a duty of 256
    assign duty = `PM_PWM_W'(power) + `PM_PWM_W'(1);

    pwm_gen u_pwm (
        .clk     (clk),
        .rst_n   (rst_n),
        .duty    (duty),
        .out_pwm (pwm_out)
    );

    // sleep wins over lowpower
    always_comb begin
        if (sleep_reg.f.sleep) begin
            cpu_enable = 1'b0;
        end else if (sleep_reg.f.lowpower) begin
            cpu_enable = pwm_out;
        end else begin
            cpu_enable = 1'b1;
        end
    end

endmodule

// ==== pwm_gen.sv ====
`timescale 1ns/1ps
`include "pm_params.svh"

// free running pwm with a fixed period
// out_pwm is high while the count is below duty, so a duty of n gives
// exactly n high cycles in every window of PM_PWM_PERIOD cycles
module pwm_gen (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`PM_PWM_W-1:0] duty,
    output logic                 out_pwm
);

    logic [`PM_PWM_W-1:0] count;
    logic                 count_wrap;

    // last count of the period
    assign count_wrap = (count == `PM_PWM_W'(`PM_PWM_PERIOD - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (count_wrap) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // duty 0 never high, duty PERIOD always high
    assign out_pwm = (count < duty);

endmodule

// ==== tb.f ====
+incdir+.
pm_pkg.sv
pwm_gen.sv
pm_regs.sv
power_manager.sv
wake_timer.sv
pm_subsystem.sv
tb_pm_subsystem.sv

// ==== tb_pm_subsystem.sv ====
`timescale 1ns/1ps
`include "pm_params.svh"

module tb_pm_subsystem;

    localparam logic [15:0] SLEEP_ADDR     = `PM_BASE_ADDR;
    localparam logic [15:0] POWER_ADDR     = `PM_BASE_ADDR + 16'd1;
    localparam logic [15:0] RELOAD_HI_ADDR = `TMR_BASE_ADDR + 16'd1;
    localparam logic [15:0] CTRL_ADDR      = `TMR_BASE_ADDR + 16'd2;
    localparam logic [15:0] STATUS_ADDR    = `TMR_BASE_ADDR + 16'd3;

    localparam logic [16:0] LFSR_SEED = 17'd90497;
    localparam int DUTY_RUNS = 4;

    // rough cycle budget per test plus a margin for the watchdog
    localparam int TEST_CYCLES = 8 + 60 + 200 + 60 + DUTY_RUNS * (256 + 20) + 300;
    localparam int TIMEOUT_NS = (TEST_CYCLES + 500) * 10;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        enable;
    logic [15:0] addr;
    logic        write_en;
    logic [7:0]  data_in;
    logic [7:0]  data_out;
    logic [3:1]  ext_irq;
    logic        cpu_enable;

    logic [16:0] lfsr_state = LFSR_SEED;
    int          cycle = 0;
    int          mismatch_count = 0;
    int          failure_count = 0;

    // expected register contents
    // power and reload low byte both decode address FF20
    logic [7:0] exp_sleep = 8'h00;
    logic [7:0] exp_power = 8'hFF;
    logic [7:0] exp_reload_lo = 8'h00;
    logic [7:0] exp_reload_hi = 8'h00;

    pm_subsystem dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .addr       (addr),
        .write_en   (write_en),
        .data_in    (data_in),
        .data_out   (data_out),
        .ext_irq    (ext_irq),
        .cpu_enable (cpu_enable)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[14:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // only sleep, power, reload high and unmapped addresses
    function automatic logic [7:0] expected_read(input logic [15:0] a);
        case (a)
            SLEEP_ADDR:     return exp_sleep;
            POWER_ADDR:     return exp_power | exp_reload_lo;
            RELOAD_HI_ADDR: return exp_reload_hi;
            default:        return 8'h00;
        endcase
    endfunction

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] got);
        assert (got === exp) else begin
            mismatch_count++;
            $display("mismatch at %0t: %s expected %02h got %02h", $time, what, exp, got);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic got);
        assert (got === exp) else begin
            mismatch_count++;
            $display("mismatch at %0t: %s expected %b got %b", $time, what, exp, got);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int got);
        assert (got == exp) else begin
            mismatch_count++;
            $display("mismatch at %0t: %s expected %0d got %0d", $time, what, exp, got);
        end
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        #1;
        enable   = 1'b1;
        write_en = 1'b1;
        addr     = a;
        data_in  = d;
        @(posedge clk);             // write lands here
        #1;
        enable   = 1'b0;
        write_en = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
        @(posedge clk);
        #1;
        enable   = 1'b1;
        write_en = 1'b0;
        addr     = a;
        #4;
        d = data_out;               // sampled mid cycle once the comb path has settled
        @(posedge clk);
        #1;
        enable = 1'b0;
    endtask

    task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
        bus_write(a, d);
        if (a == SLEEP_ADDR) exp_sleep = d;
        if (a == POWER_ADDR) begin
            exp_power     = d;
            exp_reload_lo = d;
        end
        if (a == RELOAD_HI_ADDR) exp_reload_hi = d;
    endtask

    task automatic read_and_compare(input string what, input logic [15:0] a);
        logic [7:0] got;
        bus_read(a, got);
        check_byte(what, expected_read(a), got);
    endtask

    task automatic test_reset_state;
        logic [7:0] got;
        check_bit("cpu_enable after reset", 1'b1, cpu_enable);
        read_and_compare("sleep reset", SLEEP_ADDR);
        read_and_compare("power/reload lo reset", POWER_ADDR);
        read_and_compare("reload hi reset", RELOAD_HI_ADDR);
        bus_read(CTRL_ADDR, got);
        check_byte("control reset", 8'h00, got);
        bus_read(STATUS_ADDR, got);
        check_byte("status reset", 8'h00, got);
        read_and_compare("below windows", 16'hFF1E);
        read_and_compare("above windows", 16'hFF24);
        read_and_compare("random unmapped", random_bits(16) & 16'h7FFF);
    endtask

    task automatic test_register_access;
        logic [15:0] outside;
        for (int i = 0; i < 4; i++) begin
            write_reg(SLEEP_ADDR, 8'(random_bits(8)) & 8'hFE);  // never sleep here
            write_reg(POWER_ADDR, 8'(random_bits(8)));
            write_reg(RELOAD_HI_ADDR, 8'(random_bits(8)));
            read_and_compare("sleep readback", SLEEP_ADDR);
            read_and_compare("power readback", POWER_ADDR);
            read_and_compare("reload hi readback", RELOAD_HI_ADDR);
        end
        outside = random_bits(16) & 16'h7FFF;
        bus_write(16'hFF1E, 8'(random_bits(8)));
        bus_write(16'hFF24, 8'(random_bits(8)));
        bus_write(outside, 8'(random_bits(8)));
        read_and_compare("sleep after stray writes", SLEEP_ADDR);
        read_and_compare("power after stray writes", POWER_ADDR);
        read_and_compare("reload hi after stray writes", RELOAD_HI_ADDR);
        read_and_compare("stray address", outside);
        write_reg(SLEEP_ADDR, 8'h00);
    endtask

    task automatic test_masked_wake;
        write_reg(SLEEP_ADDR, 8'h81);           // mask line 3 and sleep
        check_bit("cpu_enable asleep", 1'b0, cpu_enable);
        ext_irq = 3'b001;                       // line 1 is outside the mask
        repeat (4) @(posedge clk);
        #1;
        check_bit("cpu_enable with unmasked irq", 1'b0, cpu_enable);
        read_and_compare("sleep with unmasked irq", SLEEP_ADDR);
        ext_irq = 3'b101;
        @(posedge clk);
        #1;
        check_bit("cpu_enable after masked irq", 1'b1, cpu_enable);
        ext_irq = 3'b000;
        exp_sleep = 8'h80;                      // only the sleep bit goes
        read_and_compare("sleep after wake", SLEEP_ADDR);
        write_reg(SLEEP_ADDR, 8'h00);
    endtask

    task automatic test_lowpower_duty;
        logic [7:0] p;
        int         ones;
        for (int run = 0; run < DUTY_RUNS; run++) begin
            p = 8'(random_bits(8));
            write_reg(POWER_ADDR, p);
            write_reg(SLEEP_ADDR, 8'h02);       // lowpower
            ones = 0;
            repeat (`PM_PWM_PERIOD) begin
                @(posedge clk);
                #1;
                if (cpu_enable) ones++;
            end
            check_count("lowpower high cycles", int'(p) + 1, ones);
        end
        write_reg(SLEEP_ADDR, 8'h00);
    endtask

    task automatic test_timer_wake;
        logic [7:0] reload_val;
        logic [7:0] got;
        int         start;
        int         limit;
        int         elapsed;
        // long enough that the clear and reread finish inside one period
        reload_val = 8'd12 + 8'(random_bits(3));
        limit = int'(reload_val) + 2;
        write_reg(POWER_ADDR, reload_val);      // reload low byte
        write_reg(RELOAD_HI_ADDR, 8'h00);
        bus_write(CTRL_ADDR, 8'h03);            // run and periodic
        start = cycle;
        write_reg(SLEEP_ADDR, 8'h11);           // mask line 0 and sleep
        check_bit("cpu_enable before timer wake", 1'b0, cpu_enable);
        while (!cpu_enable && (cycle - start) < limit + 8) begin
            @(posedge clk);
            #1;
        end
        elapsed = cycle - start;
        assert (cpu_enable) else begin
            failure_count++;
            $display("%0t: core was not woken by the timer", $time);
        end
        // flag at reload+1, wake one cycle later
        assert (elapsed == limit) else begin
            mismatch_count++;
            $display("mismatch at %0t: wake after %0d cycles, %0d expected",
                     $time, elapsed, limit);
        end
        exp_sleep = 8'h10;
        read_and_compare("sleep after timer wake", SLEEP_ADDR);
        bus_read(STATUS_ADDR, got);
        check_byte("status after expiry", 8'h01, got);
        bus_write(STATUS_ADDR, 8'h01);
        bus_read(STATUS_ADDR, got);
        check_byte("status after clear", 8'h00, got);

        // second period
        while (got[0] == 1'b0 && (cycle - start) < 2 * limit + 8) begin
            bus_read(STATUS_ADDR, got);
        end
        assert (got[0]) else begin
            failure_count++;
            $display("%0t: fired flag did not set in the second period", $time);
        end
        bus_write(CTRL_ADDR, 8'h00);
        bus_write(STATUS_ADDR, 8'h01);

        bus_write(CTRL_ADDR, 8'h01);            // one-shot
        start = cycle;
        got = 8'h00;
        while (got[0] == 1'b0 && (cycle - start) < limit + 8) begin
            bus_read(STATUS_ADDR, got);
        end
        assert (got[0]) else begin
            failure_count++;
            $display("%0t: one-shot timer never fired", $time);
        end
        bus_read(CTRL_ADDR, got);
        check_byte("control after one-shot", 8'h00, got);
        bus_write(STATUS_ADDR, 8'h01);
        write_reg(SLEEP_ADDR, 8'h00);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, tests did not finish", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        enable   = 1'b0;
        addr     = '0;
        write_en = 1'b0;
        data_in  = '0;
        ext_irq  = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_register_access();
        test_masked_wake();
        test_lowpower_duty();
        test_timer_wake();

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count + failure_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== wake_timer.sv ====
`timescale 1ns/1ps
`include "pm_params.svh"

// bus mapped wake timer
// 16-bit down counter loaded from the reload registers when run is written,
// the sticky fired flag is the interrupt
module wake_timer (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             sel,
    input  pm_pkg::tmr_off_e offset,
    input  logic             write_en,
    input  logic [7:0]       data_in,
    output logic [7:0]       data_out,
    output logic             timer_irq
);

    import pm_pkg::*;

    logic [`TMR_CNT_W-1:0] reload;
    logic [`TMR_CNT_W-1:0] count;    // not visible on the bus
    logic                  run;
    logic                  periodic;
    logic                  fired;
    logic                  wr_lo;
    logic                  wr_hi;
    logic                  wr_ctrl;
    logic                  wr_stat;
    logic                  expire;

    assign wr_lo   = sel && write_en && (offset == TMR_RELOAD_LO);
    assign wr_hi   = sel && write_en && (offset == TMR_RELOAD_HI);
    assign wr_ctrl = sel && write_en && (offset == TMR_CTRL);
    assign wr_stat = sel && write_en && (offset == TMR_STATUS);

    // count reached zero while running, flag sets at this edge
    assign expire = run && (count == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reload <= '0;
        end else begin
            if (wr_lo) reload[7:0]  <= data_in;
            if (wr_hi) reload[15:8] <= data_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run      <= 1'b0;
            periodic <= 1'b0;
            count    <= '0;
        end else if (wr_ctrl) begin
            run      <= data_in[0];
            periodic <= data_in[1];
            if (data_in[0]) begin
                count <= reload;    // start or restart
            end
        end else if (expire) begin
            if (periodic) begin
                count <= reload;
            end else begin
                run <= 1'b0;        // one-shot stops here
            end
        end else if (run) begin
            count <= count - 1'b1;
        end
    end

    // sticky flag, a new expiry beats a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fired <= 1'b0;
        end else if (expire) begin
            fired <= 1'b1;
        end else if (wr_stat && data_in[0]) begin
            fired <= 1'b0;
        end
    end

    assign timer_irq = fired;

    always_comb begin
        data_out = 8'h00;
        if (sel) begin
            case (offset)
                TMR_RELOAD_LO: data_out = reload[7:0];
                TMR_RELOAD_HI: data_out = reload[15:8];
                TMR_CTRL:      data_out = {6'b0, periodic, run};
                TMR_STATUS:    data_out = {7'b0, fired};
            endcase
        end
    end

endmodule
